/* mips_pkg.sv */
package mips_pkg;

	typedef logic [31:0] word_t;     // data, address or instruction word
	typedef logic [4:0]  reg_addr_t; // register index

	typedef enum logic [5:0]
	{
		OP_RTYPE = 6'd0,
		OP_BEQ   = 6'd4,
		OP_ADDI  = 6'd8,
		OP_LW    = 6'd35,
		OP_SW    = 6'd43
	} opcode_t;

	typedef enum logic [5:0]
	{
		FN_ADD = 6'd32,
		FN_SUB = 6'd34,
		FN_AND = 6'd36,
		FN_OR  = 6'd37,
		FN_SLT = 6'd42
	} funct_t;

	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_t;

	typedef enum logic [1:0]
	{
		FWD_REG, // operand from ID/EX
		FWD_MEM, // alu result in memory stage
		FWD_WB   // writeback data
	} fwd_sel_t;

	typedef struct packed
	{
		opcode_t   opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] shamt;
		funct_t    funct;
	} r_fields_t;

	typedef struct packed
	{
		opcode_t     opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_fields_t;

	// one fetched word, seen as R-type or I-type
	typedef union packed
	{
		r_fields_t r;
		i_fields_t i;
	} instr_t;

endpackage

/* fetch_stage.sv */
`timescale 1ns/1ps
module fetch_stage import mips_pkg::*;
#(
	parameter word_t RESET_PC = '0
)
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   stall,
	input  logic   flush,
	input  word_t  branch_target,
	input  word_t  imem_data,
	output word_t  pc,
	output instr_t if_instr,
	output word_t  if_pc_next
);

	word_t pc_plus_one;

	assign pc_plus_one = pc + 32'd1; // word addressed

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pc <= RESET_PC;
		else if (flush)
			pc <= branch_target; // taken beq from execute
		else if (!stall)
			pc <= pc_plus_one;
	end

	// IF/ID register, all-zero word decodes as a bubble
	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
		begin
			if_instr   <= '0;
			if_pc_next <= '0;
		end
		else if (!stall)
		begin
			if_instr   <= imem_data;
			if_pc_next <= pc_plus_one;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) stall |=> $stable(pc));
	assert property (@(posedge clk) disable iff (!rst_n) !(stall && flush));
	// a load-use bubble never needs a second cycle
	assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall);

endmodule

/* reg_file.sv */
`timescale 1ns/1ps
module reg_file import mips_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t rs_addr,
	input  reg_addr_t rt_addr,
	output word_t     rs_data,
	output word_t     rt_data,
	input  logic      we,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data
);

	word_t regs [0:31];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && wr_addr != '0)
			regs[wr_addr] <= wr_data; // r0 stays zero
	end

	// writeback value bypasses the array in the same cycle
	assign rs_data = (rs_addr == '0) ? '0 :
		(we && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 :
		(we && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

	assert property (@(posedge clk) rs_addr == '0 |-> rs_data == '0);

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
module decode_stage import mips_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  instr_t    if_instr,
	input  word_t     if_pc_next,
	input  logic      stall,
	input  logic      flush,
	input  logic      wb_reg_write,
	input  reg_addr_t wb_dst,
	input  word_t     wb_data,
	output reg_addr_t id_rs,
	output reg_addr_t id_rt,
	output word_t     ex_rd1,
	output word_t     ex_rd2,
	output word_t     ex_imm,
	output word_t     ex_pc_next,
	output reg_addr_t ex_rs,
	output reg_addr_t ex_rt,
	output reg_addr_t ex_dst,
	output alu_op_t   ex_alu_op,
	output logic      ex_alu_src,
	output logic      ex_reg_write,
	output logic      ex_mem_read,
	output logic      ex_mem_write,
	output logic      ex_mem_to_reg,
	output logic      ex_branch
);

	word_t     rd1;
	word_t     rd2;
	word_t     imm_ext;
	reg_addr_t dst;
	alu_op_t   alu_op;
	logic      alu_src;
	logic      reg_write;
	logic      mem_read;
	logic      mem_write;
	logic      mem_to_reg;
	logic      branch;
	logic      use_rd;

	assign id_rs = if_instr.i.rs;
	assign id_rt = if_instr.i.rt;

	reg_file reg_file_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_addr (id_rs),
		.rt_addr (id_rt),
		.rs_data (rd1),
		.rt_data (rd2),
		.we      (wb_reg_write),
		.wr_addr (wb_dst),
		.wr_data (wb_data)
	);

	// main control and alu decode in one place
	always_comb
	begin
		alu_op     = ALU_ADD;
		alu_src    = 1'b0;
		reg_write  = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_to_reg = 1'b0;
		branch     = 1'b0;
		use_rd     = 1'b0;
		case (if_instr.r.opcode)
			OP_RTYPE:
			begin
				use_rd    = 1'b1;
				reg_write = 1'b1;
				case (if_instr.r.funct)
					FN_ADD: alu_op = ALU_ADD;
					FN_SUB: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR:  alu_op = ALU_OR;
					FN_SLT: alu_op = ALU_SLT;
					default: reg_write = 1'b0; // unknown funct, bubble
				endcase
			end
			OP_ADDI:
			begin
				alu_src   = 1'b1;
				reg_write = 1'b1;
			end
			OP_LW:
			begin
				alu_src    = 1'b1;
				reg_write  = 1'b1;
				mem_read   = 1'b1;
				mem_to_reg = 1'b1;
			end
			OP_SW:
			begin
				alu_src   = 1'b1;
				mem_write = 1'b1;
			end
			OP_BEQ:
			begin
				alu_op = ALU_SUB;
				branch = 1'b1; // compared in execute
			end
			default: ;
		endcase
	end

	assign imm_ext = {{16{if_instr.i.imm[15]}}, if_instr.i.imm};
	assign dst     = use_rd ? if_instr.r.rd : if_instr.i.rt;

	// ID/EX control, bubble on stall or flush
	always_ff @(posedge clk)
	begin
		if (!rst_n || stall || flush)
		begin
			ex_alu_op     <= ALU_ADD;
			ex_alu_src    <= 1'b0;
			ex_reg_write  <= 1'b0;
			ex_mem_read   <= 1'b0;
			ex_mem_write  <= 1'b0;
			ex_mem_to_reg <= 1'b0;
			ex_branch     <= 1'b0;
		end
		else
		begin
			ex_alu_op     <= alu_op;
			ex_alu_src    <= alu_src;
			ex_reg_write  <= reg_write;
			ex_mem_read   <= mem_read;
			ex_mem_write  <= mem_write;
			ex_mem_to_reg <= mem_to_reg;
			ex_branch     <= branch;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk)
	begin
		ex_rd1     <= rd1;
		ex_rd2     <= rd2;
		ex_imm     <= imm_ext;
		ex_pc_next <= if_pc_next;
		ex_rs      <= id_rs;
		ex_rt      <= id_rt;
		ex_dst     <= dst;
	end

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps
module hazard_unit import mips_pkg::*;
(
	input  reg_addr_t id_rs,
	input  reg_addr_t id_rt,
	input  logic      ex_mem_read,
	input  reg_addr_t ex_dst,
	input  reg_addr_t ex_rs,
	input  reg_addr_t ex_rt,
	input  logic      mem_reg_write,
	input  reg_addr_t mem_dst,
	input  logic      wb_reg_write,
	input  reg_addr_t wb_dst,
	input  logic      branch_taken,
	output logic      stall,
	output logic      flush,
	output fwd_sel_t  fwd_a,
	output fwd_sel_t  fwd_b
);

	logic load_use;

	// memory stage is younger, so it wins over writeback
	function automatic fwd_sel_t fwd_for(reg_addr_t src);
		if (mem_reg_write && mem_dst != '0 && mem_dst == src)
			return FWD_MEM;
		else if (wb_reg_write && wb_dst != '0 && wb_dst == src)
			return FWD_WB;
		else
			return FWD_REG;
	endfunction

	assign load_use = ex_mem_read && ex_dst != '0 &&
		(ex_dst == id_rs || ex_dst == id_rt);

	assign stall = load_use && !branch_taken; // flush wins
	assign flush = branch_taken;

	always_comb
	begin
		fwd_a = fwd_for(ex_rs);
		fwd_b = fwd_for(ex_rt);
	end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps
module execute_stage import mips_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  word_t     ex_rd1,
	input  word_t     ex_rd2,
	input  word_t     ex_imm,
	input  word_t     ex_pc_next,
	input  reg_addr_t ex_dst,
	input  alu_op_t   ex_alu_op,
	input  logic      ex_alu_src,
	input  logic      ex_reg_write,
	input  logic      ex_mem_read,
	input  logic      ex_mem_write,
	input  logic      ex_mem_to_reg,
	input  logic      ex_branch,
	input  fwd_sel_t  fwd_a,
	input  fwd_sel_t  fwd_b,
	input  word_t     wb_data,
	output logic      branch_taken,
	output word_t     branch_target,
	output word_t     mem_alu_result,
	output word_t     mem_store_data,
	output reg_addr_t mem_dst,
	output logic      mem_reg_write,
	output logic      mem_mem_read,
	output logic      mem_mem_write,
	output logic      mem_mem_to_reg
);

	word_t op_a;
	word_t fwd_rt;
	word_t op_b;
	word_t alu_result;

	function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
		word_t wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a   = fwd_mux(fwd_a, ex_rd1, mem_alu_result, wb_data);
	assign fwd_rt = fwd_mux(fwd_b, ex_rd2, mem_alu_result, wb_data);
	assign op_b   = ex_alu_src ? ex_imm : fwd_rt; // addi, lw, sw

	always_comb
	begin
		case (ex_alu_op)
			ALU_ADD: alu_result = op_a + op_b;
			ALU_SUB: alu_result = op_a - op_b;
			ALU_AND: alu_result = op_a & op_b;
			ALU_OR:  alu_result = op_a | op_b;
			ALU_SLT: alu_result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
			default: alu_result = op_a + op_b;
		endcase
	end

	assign branch_taken  = ex_branch && (op_a == fwd_rt);
	assign branch_target = ex_pc_next + ex_imm; // relative to pc+1

	// EX/MEM control
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mem_reg_write  <= 1'b0;
			mem_mem_read   <= 1'b0;
			mem_mem_write  <= 1'b0;
			mem_mem_to_reg <= 1'b0;
		end
		else
		begin
			mem_reg_write  <= ex_reg_write;
			mem_mem_read   <= ex_mem_read;
			mem_mem_write  <= ex_mem_write;
			mem_mem_to_reg <= ex_mem_to_reg;
		end
	end

	// EX/MEM payload
	always_ff @(posedge clk)
	begin
		mem_alu_result <= alu_result;
		mem_store_data <= fwd_rt; // forwarded rt for sw
		mem_dst        <= ex_dst;
	end

endmodule

/* mem_wb_stage.sv */
`timescale 1ns/1ps
module mem_wb_stage import mips_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  word_t     mem_alu_result,
	input  logic      mem_reg_write,
	input  logic      mem_mem_to_reg,
	input  reg_addr_t mem_dst,
	input  word_t     dmem_rdata,
	output logic      wb_reg_write,
	output reg_addr_t wb_dst,
	output word_t     wb_data
);

	logic  wb_mem_to_reg;
	word_t wb_alu_result;
	word_t wb_load_data;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_reg_write  <= 1'b0;
			wb_mem_to_reg <= 1'b0;
		end
		else
		begin
			wb_reg_write  <= mem_reg_write;
			wb_mem_to_reg <= mem_mem_to_reg;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_alu_result <= mem_alu_result;
		wb_load_data  <= dmem_rdata; // memory answers in the same cycle
		wb_dst        <= mem_dst;
	end

	assign wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

/* mips_core.sv */
`timescale 1ns/1ps
module mips_core import mips_pkg::*;
#(
	parameter word_t RESET_PC = '0
)
(
	input  logic  clk,
	input  logic  rst_n,
	output word_t imem_addr,
	input  word_t imem_data,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic  dmem_we,
	output logic  dmem_re,
	input  word_t dmem_rdata
);

	logic      stall;
	logic      flush;
	instr_t    if_instr;
	word_t     if_pc_next;
	reg_addr_t id_rs;
	reg_addr_t id_rt;
	word_t     ex_rd1;
	word_t     ex_rd2;
	word_t     ex_imm;
	word_t     ex_pc_next;
	reg_addr_t ex_rs;
	reg_addr_t ex_rt;
	reg_addr_t ex_dst;
	alu_op_t   ex_alu_op;
	logic      ex_alu_src;
	logic      ex_reg_write;
	logic      ex_mem_read;
	logic      ex_mem_write;
	logic      ex_mem_to_reg;
	logic      ex_branch;
	fwd_sel_t  fwd_a;
	fwd_sel_t  fwd_b;
	logic      branch_taken;
	word_t     branch_target;
	word_t     mem_alu_result;
	word_t     mem_store_data;
	reg_addr_t mem_dst;
	logic      mem_reg_write;
	logic      mem_mem_read;
	logic      mem_mem_write;
	logic      mem_mem_to_reg;
	logic      wb_reg_write;
	reg_addr_t wb_dst;
	word_t     wb_data;

	// data memory port driven from EX/MEM
	assign dmem_addr  = mem_alu_result;
	assign dmem_wdata = mem_store_data;
	assign dmem_we    = mem_mem_write;
	assign dmem_re    = mem_mem_read;

	fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.flush         (flush),
		.branch_target (branch_target),
		.imem_data     (imem_data),
		.pc            (imem_addr),
		.if_instr      (if_instr),
		.if_pc_next    (if_pc_next)
	);

	decode_stage decode_stage_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.if_instr      (if_instr),
		.if_pc_next    (if_pc_next),
		.stall         (stall),
		.flush         (flush),
		.wb_reg_write  (wb_reg_write),
		.wb_dst        (wb_dst),
		.wb_data       (wb_data),
		.id_rs         (id_rs),
		.id_rt         (id_rt),
		.ex_rd1        (ex_rd1),
		.ex_rd2        (ex_rd2),
		.ex_imm        (ex_imm),
		.ex_pc_next    (ex_pc_next),
		.ex_rs         (ex_rs),
		.ex_rt         (ex_rt),
		.ex_dst        (ex_dst),
		.ex_alu_op     (ex_alu_op),
		.ex_alu_src    (ex_alu_src),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_read   (ex_mem_read),
		.ex_mem_write  (ex_mem_write),
		.ex_mem_to_reg (ex_mem_to_reg),
		.ex_branch     (ex_branch)
	);

	hazard_unit hazard_unit_i (
		.id_rs         (id_rs),
		.id_rt         (id_rt),
		.ex_mem_read   (ex_mem_read),
		.ex_dst        (ex_dst),
		.ex_rs         (ex_rs),
		.ex_rt         (ex_rt),
		.mem_reg_write (mem_reg_write),
		.mem_dst       (mem_dst),
		.wb_reg_write  (wb_reg_write),
		.wb_dst        (wb_dst),
		.branch_taken  (branch_taken),
		.stall         (stall),
		.flush         (flush),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b)
	);

	execute_stage execute_stage_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.ex_rd1         (ex_rd1),
		.ex_rd2         (ex_rd2),
		.ex_imm         (ex_imm),
		.ex_pc_next     (ex_pc_next),
		.ex_dst         (ex_dst),
		.ex_alu_op      (ex_alu_op),
		.ex_alu_src     (ex_alu_src),
		.ex_reg_write   (ex_reg_write),
		.ex_mem_read    (ex_mem_read),
		.ex_mem_write   (ex_mem_write),
		.ex_mem_to_reg  (ex_mem_to_reg),
		.ex_branch      (ex_branch),
		.fwd_a          (fwd_a),
		.fwd_b          (fwd_b),
		.wb_data        (wb_data),
		.branch_taken   (branch_taken),
		.branch_target  (branch_target),
		.mem_alu_result (mem_alu_result),
		.mem_store_data (mem_store_data),
		.mem_dst        (mem_dst),
		.mem_reg_write  (mem_reg_write),
		.mem_mem_read   (mem_mem_read),
		.mem_mem_write  (mem_mem_write),
		.mem_mem_to_reg (mem_mem_to_reg)
	);

	mem_wb_stage mem_wb_stage_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_alu_result (mem_alu_result),
		.mem_reg_write  (mem_reg_write),
		.mem_mem_to_reg (mem_mem_to_reg),
		.mem_dst        (mem_dst),
		.dmem_rdata     (dmem_rdata),
		.wb_reg_write   (wb_reg_write),
		.wb_dst         (wb_dst),
		.wb_data        (wb_data)
	);

endmodule

/* tb_mips_core.sv */
`timescale 1ns/1ps
module tb_mips_core;

	localparam int CLK_PERIOD      = 8;
	localparam int RUN_CYCLES      = 40;
	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 60;

	localparam logic [31:0] LFSR_SEED = 32'h8074_3937;
	localparam logic [31:0] LFSR_TAPS = 32'hA300_0000; // x^32+x^30+x^26+x^25+1

	localparam logic [5:0] OPC_R    = 6'd0;
	localparam logic [5:0] OPC_BEQ  = 6'd4;
	localparam logic [5:0] OPC_ADDI = 6'd8;
	localparam logic [5:0] OPC_LW   = 6'd35;
	localparam logic [5:0] OPC_SW   = 6'd43;
	localparam logic [5:0] F_ADD    = 6'd32;
	localparam logic [5:0] F_SUB    = 6'd34;
	localparam logic [5:0] F_AND    = 6'd36;
	localparam logic [5:0] F_OR     = 6'd37;
	localparam logic [5:0] F_SLT    = 6'd42;

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	logic        dmem_re;
	logic [31:0] dmem_rdata;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] dmem_init [0:255]; // loaded into dmem during reset
	logic [31:0] log_addr [$];
	logic [31:0] log_data [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] load_log [$];
	logic [31:0] exp_load [$];
	logic [31:0] lfsr_state;
	int          prog_len;

	mips_core #(.RESET_PC(32'd0)) dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_re    (dmem_re),
		.dmem_rdata (dmem_rdata)
	);

	assign imem_data  = imem[imem_addr[7:0]]; // word addressed
	assign dmem_rdata = dmem[dmem_addr[7:0]];

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// data memory writes, the store log and the load log
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			dmem <= dmem_init;
			log_addr.delete();
			log_data.delete();
			load_log.delete();
		end
		else
		begin
			if (dmem_we)
			begin
				dmem[dmem_addr[7:0]] <= dmem_wdata;
				log_addr.push_back(dmem_addr);
				log_data.push_back(dmem_wdata);
			end
			if (dmem_re)
				load_log.push_back(dmem_addr); // one entry per lw in memory stage
		end
	end

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("Mismatch %s: got %h, expected %h", name, got, expected);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic rand_word(output logic [31:0] w);
		w = '0;
		for (int k = 0; k < 32; k++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {OPC_R, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// differing signs decide alone, equal signs order like unsigned
	function automatic logic [31:0] signed_less(input logic [31:0] a, input logic [31:0] b);
		if (a[31] != b[31])
			return {31'd0, a[31]};
		return {31'd0, a < b};
	endfunction

	task automatic new_program();
		for (int i = 0; i < 256; i++)
		begin
			imem[i]      = {OPC_R, 15'(i), 5'd0, 6'h3f}; // undefined funct
			dmem_init[i] = 32'hDA7A_0000 | 32'(i);
		end
		prog_len = 0;
		exp_addr.delete();
		exp_data.delete();
		exp_load.delete();
	endtask

	task automatic emit(input logic [31:0] w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic finish_program();
		emit(enc_i(OPC_BEQ, 5'd0, 5'd0, 16'hFFFF)); // branch to itself
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic expect_load(input logic [31:0] addr);
		exp_load.push_back(addr);
	endtask

	task automatic reset_and_run();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		repeat (RUN_CYCLES) @(posedge clk);
		@(negedge clk); // log settled
	endtask

	task automatic compare_memory_logs(input string test_name);
		if (log_addr.size() != exp_addr.size())
		begin
			$display("%s: expected %0d stores but the core made %0d", test_name,
				exp_addr.size(), log_addr.size());
			abort_run();
		end
		for (int k = 0; k < exp_addr.size(); k++)
		begin
			check($sformatf("dmem_addr[%0d]", k), log_addr[k], exp_addr[k]);
			check($sformatf("dmem_wdata[%0d]", k), log_data[k], exp_data[k]);
		end
		if (load_log.size() != exp_load.size())
		begin
			$display("%s: expected %0d loads but the core made %0d", test_name,
				exp_load.size(), load_log.size());
			abort_run();
		end
		for (int k = 0; k < exp_load.size(); k++)
			check($sformatf("dmem_re addr[%0d]", k), load_log[k], exp_load[k]);
	endtask

	task automatic forwarding_chain();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sum;
		logic [31:0] diff;
		logic [31:0] conj;
		logic [31:0] disj;
		a    = 32'd25;
		b    = 32'hFFFF_FFF9; // -7
		sum  = a + b;
		diff = sum - a;
		conj = diff & sum;
		disj = conj | b;
		new_program();
		emit(enc_i(OPC_ADDI, 5'd1, 5'd0, 16'd25));
		emit(enc_i(OPC_ADDI, 5'd2, 5'd0, 16'hFFF9));
		emit(enc_r(F_ADD, 5'd3, 5'd1, 5'd2));
		emit(enc_r(F_SUB, 5'd4, 5'd3, 5'd1));
		emit(enc_r(F_AND, 5'd5, 5'd4, 5'd3));
		emit(enc_r(F_OR, 5'd6, 5'd5, 5'd2));
		emit(enc_r(F_SLT, 5'd7, 5'd2, 5'd1));
		emit(enc_r(F_SLT, 5'd8, 5'd1, 5'd2));
		emit(enc_i(OPC_SW, 5'd8, 5'd0, 16'd6)); // store data straight from slt
		emit(enc_i(OPC_SW, 5'd7, 5'd0, 16'd5));
		emit(enc_i(OPC_SW, 5'd3, 5'd0, 16'd0));
		emit(enc_i(OPC_SW, 5'd4, 5'd0, 16'd1));
		emit(enc_i(OPC_SW, 5'd5, 5'd0, 16'd2));
		emit(enc_i(OPC_SW, 5'd6, 5'd0, 16'd3));
		finish_program();
		expect_store(32'd6, signed_less(a, b));
		expect_store(32'd5, signed_less(b, a));
		expect_store(32'd0, sum);
		expect_store(32'd1, diff);
		expect_store(32'd2, conj);
		expect_store(32'd3, disj);
		reset_and_run();
		compare_memory_logs("forwarding");
	endtask

	task automatic load_use_stall();
		new_program();
		dmem_init[10] = 32'h7FFF_FFF0;
		dmem_init[11] = 32'h0BAD_F00D;
		emit(enc_i(OPC_ADDI, 5'd1, 5'd0, 16'd100));
		emit(enc_i(OPC_LW, 5'd2, 5'd0, 16'd10));
		emit(enc_r(F_ADD, 5'd3, 5'd2, 5'd1)); // needs the bubble
		emit(enc_i(OPC_SW, 5'd3, 5'd0, 16'd20));
		emit(enc_i(OPC_LW, 5'd4, 5'd0, 16'd11));
		emit(enc_i(OPC_SW, 5'd4, 5'd0, 16'd21));
		finish_program();
		expect_load(32'd10);
		expect_load(32'd11);
		expect_store(32'd20, dmem_init[10] + 32'd100);
		expect_store(32'd21, dmem_init[11]);
		reset_and_run();
		compare_memory_logs("load-use");
	endtask

	task automatic branch_taken_flush();
		new_program();
		emit(enc_i(OPC_ADDI, 5'd1, 5'd0, 16'd5));
		emit(enc_i(OPC_ADDI, 5'd2, 5'd0, 16'd5));
		emit(enc_i(OPC_BEQ, 5'd2, 5'd1, 16'd2)); // to index 5
		emit(enc_i(OPC_SW, 5'd1, 5'd0, 16'd30)); // squashed
		emit(enc_i(OPC_SW, 5'd2, 5'd0, 16'd31)); // squashed
		emit(enc_i(OPC_ADDI, 5'd3, 5'd0, 16'd9));
		emit(enc_i(OPC_SW, 5'd3, 5'd0, 16'd32));
		finish_program();
		expect_store(32'd32, 32'd9);
		reset_and_run();
		compare_memory_logs("beq taken");
	endtask

	task automatic branch_fall_through();
		new_program();
		emit(enc_i(OPC_ADDI, 5'd1, 5'd0, 16'd3));
		emit(enc_i(OPC_ADDI, 5'd2, 5'd0, 16'd4));
		emit(enc_i(OPC_BEQ, 5'd2, 5'd1, 16'd2)); // would skip both stores
		emit(enc_i(OPC_SW, 5'd1, 5'd0, 16'd40));
		emit(enc_i(OPC_SW, 5'd2, 5'd0, 16'd41));
		finish_program();
		expect_store(32'd40, 32'd3);
		expect_store(32'd41, 32'd4);
		reset_and_run();
		compare_memory_logs("beq not taken");
	endtask

	task automatic zero_register();
		new_program();
		emit(enc_i(OPC_ADDI, 5'd0, 5'd0, 16'd77));
		emit(enc_i(OPC_SW, 5'd0, 5'd0, 16'd50));
		emit(enc_i(OPC_ADDI, 5'd1, 5'd0, 16'd1));
		emit(enc_i(OPC_SW, 5'd1, 5'd0, 16'd51));
		finish_program();
		expect_store(32'd50, 32'd0);
		expect_store(32'd51, 32'd1);
		reset_and_run();
		compare_memory_logs("register 0");
	endtask

	task automatic random_operands();
		logic [31:0] w [4];
		new_program();
		for (int k = 0; k < 4; k++)
		begin
			rand_word(w[k]);
			dmem_init[60 + k] = w[k];
		end
		emit(enc_i(OPC_LW, 5'd1, 5'd0, 16'd60));
		emit(enc_i(OPC_LW, 5'd2, 5'd0, 16'd61));
		emit(enc_r(F_ADD, 5'd3, 5'd1, 5'd2));
		emit(enc_r(F_SUB, 5'd4, 5'd1, 5'd2));
		emit(enc_r(F_SLT, 5'd5, 5'd1, 5'd2));
		emit(enc_i(OPC_LW, 5'd6, 5'd0, 16'd62));
		emit(enc_i(OPC_LW, 5'd7, 5'd0, 16'd63));
		emit(enc_r(F_SLT, 5'd8, 5'd7, 5'd6));
		emit(enc_r(F_SUB, 5'd9, 5'd7, 5'd6));
		emit(enc_i(OPC_SW, 5'd3, 5'd0, 16'd70));
		emit(enc_i(OPC_SW, 5'd4, 5'd0, 16'd71));
		emit(enc_i(OPC_SW, 5'd5, 5'd0, 16'd72));
		emit(enc_i(OPC_SW, 5'd8, 5'd0, 16'd73));
		emit(enc_i(OPC_SW, 5'd9, 5'd0, 16'd74));
		finish_program();
		for (int k = 0; k < 4; k++)
			expect_load(32'd60 + 32'(k));
		expect_store(32'd70, w[0] + w[1]);
		expect_store(32'd71, w[0] - w[1]);
		expect_store(32'd72, signed_less(w[0], w[1]));
		expect_store(32'd73, signed_less(w[3], w[2]));
		expect_store(32'd74, w[3] - w[2]);
		reset_and_run();
		compare_memory_logs("random operands");
	endtask

	initial
	begin
		rst_n      = 1'b0;
		lfsr_state = LFSR_SEED;
		new_program();
		forwarding_chain();
		load_use_stall();
		branch_taken_flush();
		branch_fall_through();
		zero_register();
		random_operands();
		$display("Test OK");
		$finish;
	end

	// watchdog
	initial
	begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("Watchdog timeout: the tests did not finish in time");
		abort_run();
	end

endmodule

/* src.f */
mips_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
mem_wb_stage.sv
mips_core.sv
tb_mips_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
